// File: src.f
rv_pkg.sv
rv_decode_if.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_pc_unit.sv
rv_core.sv
tb_rv_checker.sv
tb_rv_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it into sim.log and check the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -f src.f --top-module tb_rv_core -o tb_rv_core \
  && ./obj_dir/tb_rv_core > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

  logic      clk;
  logic      rst;
  word_t     i_insn;
  word_t     o_pc;
  logic      o_halt;
  logic      o_rf_we;
  reg_addr_t o_rf_rd;
  word_t     o_rf_wdata;
  int        n_checks;
  int        n_errors;
  int        limit_ns;
  bit        prog_ready;
  word_t     prog [$];  // Instruction memory of one word per entry

  rv_core DUT (.*);

  tb_rv_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .i_insn     (i_insn),
    .i_pc       (o_pc),
    .i_halt     (o_halt),
    .i_rf_we    (o_rf_we),
    .i_rf_rd    (o_rf_rd),
    .i_rf_wdata (o_rf_wdata),
    .o_checks   (n_checks),
    .o_errors   (n_errors)
  );

  // RV32I instruction encoders
  function automatic word_t itype_word(opcode_e op, int rd, int f3, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic word_t rtype_word(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg_reg};
  endfunction

  function automatic word_t btype_word(int f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], op_branch};
  endfunction

  function automatic word_t utype_word(opcode_e op, int rd, int hi);
    return {hi[19:0], rd[4:0], op};
  endfunction

  function automatic word_t jtype_word(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
  endfunction

  // Past the end of the program the memory returns ECALL
  function automatic word_t fetch_word(word_t pc);
    int idx;
    idx = int'(pc >> 2);
    if (idx < prog.size()) begin
      return prog[idx];
    end
    return 32'h0000_0073;
  endfunction

  // LUI/ADDI load the target into rx, then JALR with an odd offset
  task automatic jump_via_reg(int rx, int rd, int target_idx);
    int t;
    int hi;
    t  = target_idx * 4;
    hi = (t + 'h800) >> 12;  // Rounded so the low part fits ADDI
    prog.push_back(utype_word(op_lui, rx, hi));
    prog.push_back(itype_word(op_reg_imm, rx, 0, rx, t - (hi << 12)));
    prog.push_back(itype_word(op_jalr, rd, 0, rx, 1));  // Bit 0 must be dropped
  endtask

  task automatic build_program();
    int bf [6] = '{0, 1, 4, 5, 6, 7};  // Branch funct3 codes
    int ra [3] = '{1, 3, 3};
    int rb [3] = '{2, 1, 3};
    int body_end;
    int max_target;
    int i;
    int k;
    int sel;
    int rd;
    int rs1;
    int rs2;
    int f3;
    int imm;
    int tgt;
    for (int r = 1; r < num_regs; r++) begin
      prog.push_back(itype_word(op_reg_imm, r, 0, r, 0));  // Reads reset value
    end
    prog.push_back(utype_word(op_lui, 1, 'h80000));       // x1 = 8000_0000
    prog.push_back(itype_word(op_reg_imm, 2, 0, 0, -1));  // x2 = ffff_ffff
    prog.push_back(itype_word(op_reg_imm, 3, 0, 0, 5));
    prog.push_back(utype_word(op_auipc, 4, 'h12345));
    for (int f = 0; f < 8; f++) begin
      prog.push_back(rtype_word(0, 3, 1, f, 10 + f));
      prog.push_back(itype_word(op_reg_imm, 20 + f, f, 1, (f == 1 || f == 5) ? 7 : -3));
    end
    prog.push_back(rtype_word(32, 3, 1, 0, 18));               // SUB
    prog.push_back(rtype_word(32, 3, 1, 5, 19));               // SRA
    prog.push_back(itype_word(op_reg_imm, 28, 5, 1, 'h407));  // SRAI
    prog.push_back(rtype_word(0, 2, 1, 0, 0));                 // Write to x0
    prog.push_back(itype_word(op_reg_imm, 7, 0, 0, 0));
    // Negative, all-ones and equal operand pairs
    for (int b = 0; b < 6; b++) begin
      for (int p = 0; p < 3; p++) begin
        prog.push_back(btype_word(bf[b], ra[p], rb[p], 8));
        prog.push_back(itype_word(op_reg_imm, 8, 0, 8, 1));  // Skipped when taken
      end
    end
    prog.push_back(jtype_word(9, 8));
    prog.push_back(itype_word(op_reg_imm, 8, 0, 8, 1));
    jump_via_reg(11, 12, prog.size() + 4);
    prog.push_back(itype_word(op_reg_imm, 8, 0, 8, 1));
    prog.push_back(32'h0ff0_000f);  // FENCE
    prog.push_back(32'h0000_a083);  // LW
    prog.push_back(32'h0000_007f);  // Unknown opcode

    body_end   = prog.size() + 150;
    max_target = 0;
    while (prog.size() < body_end) begin
      i   = prog.size();
      sel = $urandom_range(0, 7);
      rd  = $urandom_range(0, 31);
      rs1 = $urandom_range(0, 31);
      rs2 = $urandom_range(0, 31);
      f3  = $urandom_range(0, 7);
      imm = $urandom_range(0, 4095);
      k   = $urandom_range(1, 4);
      if (i + k > body_end) begin
        k = body_end - i;  // Stay inside the program
      end
      case (sel)
        0, 1: begin
          if (f3 == 1 || f3 == 5) begin
            imm = imm & ((f3 == 5) ? 'h41f : 'h1f);
          end
          prog.push_back(itype_word(op_reg_imm, rd, f3, rs1, imm));
        end
        2: begin
          prog.push_back(rtype_word(((f3 == 0 || f3 == 5) && $urandom_range(0, 1) == 1) ? 32 : 0,
                                    rs2, rs1, f3, rd));
        end
        3: begin
          prog.push_back(utype_word(($urandom_range(0, 1) == 1) ? op_lui : op_auipc, rd,
                                    $urandom_range(0, 'hfffff)));
        end
        4, 5: begin
          if (sel == 4) begin
            prog.push_back(btype_word(bf[$urandom_range(0, 5)], rs1, rs2, k * 4));
          end else begin
            prog.push_back(jtype_word(rd, k * 4));
          end
          max_target = (i + k > max_target) ? i + k : max_target;
        end
        6: begin
          // No earlier jump may land inside the three-word sequence
          if (max_target <= i && i + 3 <= body_end) begin
            tgt = (i + 2 + k > body_end) ? body_end : i + 2 + k;
            jump_via_reg((rs1 == 0) ? 5 : rs1, rd, tgt);
            max_target = tgt;
          end else begin
            prog.push_back(itype_word(op_reg_imm, rd, 0, rs1, imm));
          end
        end
        default: begin
          prog.push_back(imm[0] ? 32'h0ff0_000f : word_t'((imm << 7) | 'h7f));
        end
      endcase
    end
    prog.push_back(32'h0000_0073);  // ECALL
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    #1;
    i_insn = fetch_word(o_pc);
  end

  initial begin
    void'($urandom(32'h9d80_a804));
    rst        = 1'b1;
    i_insn     = '0;
    prog_ready = 1'b0;
    build_program();
    prog_ready = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    while (o_halt !== 1'b1) begin
      @(negedge clk);
    end
    repeat (5) @(negedge clk);  // PC must hold while halted
    @(posedge clk);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0 && n_checks > 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (prog_ready);
    limit_ns = (prog.size() + 20) * 10 * 2;
    #(limit_ns);
    $display("Timeout: the core did not reach ECALL within %0d ns", limit_ns);
    $display("Done: errors found");
    $finish;
  end

endmodule

// File: tb_rv_checker.sv
`timescale 1ns/1ps

module tb_rv_checker import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  word_t     i_insn,
  input  word_t     i_pc,
  input  logic      i_halt,
  input  logic      i_rf_we,
  input  reg_addr_t i_rf_rd,
  input  word_t     i_rf_wdata,
  output int        o_checks,
  output int        o_errors
);

  word_t     regs_m [num_regs];  // Model register file
  word_t     pc_m;
  logic      exp_we;
  reg_addr_t exp_rd;
  word_t     exp_wdata;
  word_t     exp_next;
  logic      exp_halt;

  initial begin
    o_checks = 0;
    o_errors = 0;
  end

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t x, word_t y);
    logic [4:0] sh;
    sh = y[4:0];
    case (f3)
      3'd0:    return alt ? x - y : x + y;
      3'd1:    return x << sh;
      3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3:    return (x < y) ? 32'd1 : 32'd0;
      3'd4:    return x ^ y;
      3'd5:    return (x >> sh) | ((alt && x[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
      3'd6:    return x | y;
      default: return x & y;
    endcase
  endfunction

  // Expected retire record and next PC for one instruction
  function automatic void predict(input word_t insn, input word_t pc, input word_t a,
                                  input word_t b, output logic we, output reg_addr_t rd,
                                  output word_t wdata, output word_t next, output logic halt);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       take;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    f3    = insn[14:12];
    f7    = insn[31:25];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    imm_u = {insn[31:12], 12'h000};
    we    = 1'b0;
    rd    = insn[11:7];
    wdata = '0;
    halt  = 1'b0;
    next  = pc + 32'd4;
    case (insn[6:0])
      op_lui: begin
        we    = 1'b1;
        wdata = imm_u;
      end
      op_auipc: begin
        we    = 1'b1;
        wdata = pc + imm_u;
      end
      op_jal: begin
        we    = 1'b1;
        wdata = pc + 32'd4;
        next  = pc + imm_j;
      end
      op_jalr: begin
        if (f3 == 3'd0) begin
          we    = 1'b1;
          wdata = pc + 32'd4;
          next  = (a + imm_i) & ~32'd1;
        end
      end
      op_branch: begin
        case (f3)
          3'd0:    take = (a == b);
          3'd1:    take = (a != b);
          3'd4:    take = ($signed(a) < $signed(b));
          3'd5:    take = !($signed(a) < $signed(b));
          3'd6:    take = (a < b);
          3'd7:    take = !(a < b);
          default: take = 1'b0;
        endcase
        if (take) begin
          next = pc + imm_b;
        end
      end
      op_reg_imm: begin
        // Shift immediates carry funct7 in the upper bits
        if ((f3 != 3'd1 && f3 != 3'd5) || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20)) begin
          we    = 1'b1;
          wdata = alu_ref(f3, (f3 == 3'd5) && insn[30], a, imm_i);
        end
      end
      op_reg_reg: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          we    = 1'b1;
          wdata = alu_ref(f3, f7 == 7'h20, a, b);
        end
      end
      op_system: begin
        if (insn[31:7] == '0) begin
          halt = 1'b1;
          next = pc;
        end
      end
      default: begin
        we = 1'b0;  // FENCE, loads, stores, unknown
      end
    endcase
  endfunction

  task automatic check_value(string name, word_t expected, word_t actual);
    o_checks++;
    if (actual !== expected) begin
      o_errors++;
      $display("Fail at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // Sampled mid-cycle where inputs and outputs are settled
  always @(negedge clk) begin
    if (rst) begin
      pc_m = '0;
      for (int r = 0; r < num_regs; r++) begin
        regs_m[r] = '0;
      end
    end else begin
      predict(i_insn, pc_m, regs_m[i_insn[19:15]], regs_m[i_insn[24:20]],
              exp_we, exp_rd, exp_wdata, exp_next, exp_halt);
      check_value("o_pc", pc_m, i_pc);
      check_value("o_halt", word_t'(exp_halt), word_t'(i_halt));
      check_value("o_rf_we", word_t'(exp_we), word_t'(i_rf_we));
      if (exp_we) begin
        check_value("o_rf_rd", word_t'(exp_rd), word_t'(i_rf_rd));
        check_value("o_rf_wdata", exp_wdata, i_rf_wdata);
        if (exp_rd != '0) begin
          regs_m[exp_rd] = exp_wdata;
        end
      end
      pc_m = exp_next;
    end
  end

endmodule

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  word_t     i_insn,     // Fetched word for o_pc, same cycle
  output word_t     o_pc,
  output logic      o_halt,
  output logic      o_rf_we,    // Retire record
  output reg_addr_t o_rf_rd,
  output word_t     o_rf_wdata
);

  rv_decode_if dec_if ();

  word_t rs1_data;
  word_t rs2_data;

  rv_decoder u_decoder (
    .i_insn (i_insn),
    .dec    (dec_if)
  );

  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (dec_if.rs1),
    .i_rs2      (dec_if.rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (o_rf_we),
    .i_rd       (dec_if.rd),
    .i_wdata    (o_rf_wdata)
  );

  rv_execute u_execute (
    .dec        (dec_if),
    .i_pc       (o_pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_we       (o_rf_we),
    .o_wdata    (o_rf_wdata)
  );

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .dec        (dec_if),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_pc       (o_pc),
    .o_halt     (o_halt)
  );

  assign o_rf_rd = dec_if.rd;  // Reported even for x0

endmodule

// File: rv_pc_unit.sv
`timescale 1ns/1ps

module rv_pc_unit import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  rv_decode_if.user dec,
  input  word_t     i_rs1_data,
  input  word_t     i_rs2_data,
  output word_t     o_pc,
  output logic      o_halt
);

  word_t pc_q;
  word_t pc_next;
  word_t seq_pc;    // Fall-through address
  word_t rel_pc;    // PC-relative target for branch and JAL
  word_t jalr_sum;
  logic  taken;

  assign seq_pc   = pc_q + word_t'(pc_step);
  assign rel_pc   = pc_q + dec.imm;
  assign jalr_sum = i_rs1_data + dec.imm;

  // Branch condition straight from funct3
  always_comb begin
    case (dec.funct3)
      3'b000:  taken = (i_rs1_data == i_rs2_data);                  // BEQ
      3'b001:  taken = (i_rs1_data != i_rs2_data);                  // BNE
      3'b100:  taken = ($signed(i_rs1_data) < $signed(i_rs2_data));  // BLT
      3'b101:  taken = ($signed(i_rs1_data) >= $signed(i_rs2_data)); // BGE
      3'b110:  taken = (i_rs1_data < i_rs2_data);                   // BLTU
      3'b111:  taken = (i_rs1_data >= i_rs2_data);                  // BGEU
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (dec.kind)
      kind_branch: pc_next = taken ? rel_pc : seq_pc;
      kind_jal:    pc_next = rel_pc;
      kind_jalr:   pc_next = {jalr_sum[xlen-1:1], 1'b0};  // Bit 0 cleared
      kind_halt:   pc_next = pc_q;  // Hold until reset
      default:     pc_next = seq_pc;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q <= '0;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign o_pc   = pc_q;
  assign o_halt = (dec.kind == kind_halt);

endmodule

// File: rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_pkg::*; (
  rv_decode_if.user dec,
  input  word_t     i_pc,
  input  word_t     i_rs1_data,
  input  word_t     i_rs2_data,
  output logic      o_we,
  output word_t     o_wdata
);

  word_t      op_b;
  logic [4:0] shamt;
  word_t      alu_res;
  word_t      link_addr;

  assign op_b      = dec.use_imm ? dec.imm : i_rs2_data;
  assign shamt     = op_b[4:0];  // Shifts use low five bits only
  assign link_addr = i_pc + word_t'(pc_step);

  always_comb begin
    case (dec.alu_op)
      alu_add: begin
        alu_res = i_rs1_data + op_b;
      end
      alu_sub: begin
        alu_res = i_rs1_data - op_b;
      end
      alu_sll: begin
        alu_res = i_rs1_data << shamt;
      end
      alu_slt: begin
        alu_res = word_t'($signed(i_rs1_data) < $signed(op_b));
      end
      alu_sltu: begin
        alu_res = word_t'(i_rs1_data < op_b);
      end
      alu_xor: begin
        alu_res = i_rs1_data ^ op_b;
      end
      alu_srl: begin
        alu_res = i_rs1_data >> shamt;
      end
      alu_sra: begin
        alu_res = word_t'($signed(i_rs1_data) >>> shamt);  // Keeps sign bit
      end
      alu_or: begin
        alu_res = i_rs1_data | op_b;
      end
      default: begin
        alu_res = i_rs1_data & op_b;
      end
    endcase
  end

  // Write-back select
  always_comb begin
    o_we = 1'b1;
    case (dec.kind)
      kind_alu:            o_wdata = alu_res;
      kind_lui:            o_wdata = dec.imm;
      kind_auipc:          o_wdata = i_pc + dec.imm;
      kind_jal, kind_jalr: o_wdata = link_addr;  // Return address
      default: begin
        o_we    = 1'b0;  // Branch, halt, no-op
        o_wdata = alu_res;
      end
    endcase
  end

endmodule

// File: rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t i_rs1,
  input  reg_addr_t i_rs2,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data,
  input  logic      i_we,
  input  reg_addr_t i_rd,
  input  word_t     i_wdata
);

  word_t regs [num_regs];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin  // x0 stays zero
      regs[i_rd] <= i_wdata;
    end
  end

  // Combinational reads
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_pkg::*; (
  input  word_t    i_insn,
  rv_decode_if.dec dec
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       std_f7;    // funct7 all zero
  logic       alt_f7;    // funct7 = 0100000, SUB and SRA
  logic       shift_ok;  // Legal funct7 for an immediate shift
  alu_op_e    alu_base;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = opcode_e'(i_insn[6:0]);
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];

  assign std_f7 = (funct7 == 7'b0000000);
  assign alt_f7 = (funct7 == 7'b0100000);

  // Register fields pass straight through
  assign dec.rd     = i_insn[11:7];
  assign dec.rs1    = i_insn[19:15];
  assign dec.rs2    = i_insn[24:20];
  assign dec.funct3 = funct3;

  // Immediates, all sign-extended from bit 31
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_b = {{20{i_insn[31]}}, i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j = {{12{i_insn[31]}}, i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  // Same funct3 map for register-immediate and register-register forms
  always_comb begin
    case (funct3)
      3'b000:  alu_base = alt_f7 ? alu_sub : alu_add;
      3'b001:  alu_base = alu_sll;
      3'b010:  alu_base = alu_slt;
      3'b011:  alu_base = alu_sltu;
      3'b100:  alu_base = alu_xor;
      3'b101:  alu_base = alt_f7 ? alu_sra : alu_srl;
      3'b110:  alu_base = alu_or;
      default: alu_base = alu_and;
    endcase
  end

  // SLLI needs funct7 zero, SRLI/SRAI allow the alternate form
  always_comb begin
    case (funct3)
      3'b001:  shift_ok = std_f7;
      3'b101:  shift_ok = std_f7 || alt_f7;
      default: shift_ok = 1'b1;
    endcase
  end

  always_comb begin
    dec.kind    = kind_nop;
    dec.alu_op  = alu_add;
    dec.use_imm = 1'b0;
    dec.imm     = imm_i;
    case (opcode)
      op_lui: begin
        dec.kind = kind_lui;
        dec.imm  = imm_u;
      end
      op_auipc: begin
        dec.kind = kind_auipc;
        dec.imm  = imm_u;
      end
      op_jal: begin
        dec.kind = kind_jal;
        dec.imm  = imm_j;
      end
      op_jalr: begin
        if (funct3 == 3'b000) begin
          dec.kind = kind_jalr;
        end
      end
      op_branch: begin
        dec.imm = imm_b;
        if (funct3 != 3'b010 && funct3 != 3'b011) begin  // 010 and 011 unused
          dec.kind = kind_branch;
        end
      end
      op_reg_imm: begin
        dec.use_imm = 1'b1;
        dec.alu_op  = (funct3 == 3'b000) ? alu_add : alu_base;  // No SUBI
        if (shift_ok) begin
          dec.kind = kind_alu;
        end
      end
      op_reg_reg: begin
        dec.alu_op = alu_base;
        if (std_f7 || (alt_f7 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          dec.kind = kind_alu;
        end
      end
      op_system: begin
        if (i_insn[31:7] == '0) begin
          dec.kind = kind_halt;  // ECALL only
        end
      end
      default: begin
        dec.kind = kind_nop;  // Loads, stores, FENCE, unknown
      end
    endcase
  end

endmodule

// File: rv_decode_if.sv
`timescale 1ns/1ps

// Decoded instruction, decoder to execute and PC units
interface rv_decode_if import rv_pkg::*; ();

  insn_kind_e kind;
  alu_op_e    alu_op;
  logic       use_imm;  // Immediate replaces rs2 as operand b
  word_t      imm;      // Sign-extended, format picked by decoder
  logic [2:0] funct3;   // Branch condition code
  reg_addr_t  rd;
  reg_addr_t  rs1;
  reg_addr_t  rs2;

  // Decoder side
  modport dec (
    output kind, alu_op, use_imm, imm, funct3, rd, rs1, rs2
  );

  // Execute and PC unit side
  modport user (
    input kind, alu_op, use_imm, imm, funct3, rd, rs1, rs2
  );

endinterface

// File: rv_pkg.sv
package rv_pkg;

  localparam int xlen       = 32;  // Register and PC width
  localparam int num_regs   = 32;
  localparam int reg_addr_w = 5;
  localparam int pc_step    = 4;   // Bytes per instruction

  // One register value, address or instruction word
  typedef logic [xlen-1:0] word_t;

  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // RV32I major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    op_lui      = 7'b0110111,
    op_auipc    = 7'b0010111,
    op_jal      = 7'b1101111,
    op_jalr     = 7'b1100111,
    op_branch   = 7'b1100011,
    op_load     = 7'b0000011,  // Not executed by this core
    op_store    = 7'b0100011,  // Not executed by this core
    op_reg_imm  = 7'b0010011,
    op_reg_reg  = 7'b0110011,
    op_misc_mem = 7'b0001111,  // FENCE runs as a no-op
    op_system   = 7'b1110011
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // Instruction classes seen by execute and PC logic
  typedef enum logic [2:0] {
    kind_nop,     // No write, PC + 4
    kind_alu,
    kind_lui,
    kind_auipc,
    kind_branch,
    kind_jal,
    kind_jalr,
    kind_halt     // ECALL
  } insn_kind_e;

endpackage
